//--- boundary_tracker.sv
`timescale 1ns/1ns

module boundary_tracker #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0
) (
    input  logic clk,
    input  logic reset,
    input  logic in_loading,
    input  logic entering_grow,
    input  logic is_odd_cluster,
    output logic boundary_reached
);
    import pu_pkg::*;

    logic has_boundary_z;
    logic has_boundary_ud;
    logic grow_step;        // one step per grow stage of an odd cluster

    boundary_count_t count_z;
    boundary_count_t count_ud;

    // fixed by position in the lattice
    assign has_boundary_z = (J == 0) || (J == CODE_DISTANCE_Z - 1);
    assign has_boundary_ud = (K == 0); // bottom measurement round

    assign grow_step = entering_grow && is_odd_cluster;

    always_ff @(posedge clk) begin
        if (reset || in_loading) begin
            count_z <= '0;
            count_ud <= '0;
        end else if (grow_step) begin
            if (has_boundary_z && (count_z < BOUNDARY_COST_Z)) begin
                count_z <= count_z + 2'd1;
            end
            if (has_boundary_ud && (count_ud < BOUNDARY_COST_UD)) begin
                count_ud <= count_ud + 2'd1;
            end
        end
    end

    assign boundary_reached = (has_boundary_z && (count_z == BOUNDARY_COST_Z))
        || (has_boundary_ud && (count_ud == BOUNDARY_COST_UD));

    // counters saturate and stay at zero without a boundary
    a_counters_bounded: assert property (
        @(posedge clk) disable iff (reset)
        (count_z <= BOUNDARY_COST_Z) && (count_ud <= BOUNDARY_COST_UD)
        && (has_boundary_z || count_z == '0)
        && (has_boundary_ud || count_ud == '0)
    ) else $error("boundary counter out of range at (%0d,%0d,%0d)", I, J, K);

endmodule

//--- build.f
+incdir+.
pu_pkg.sv
stage_tracker.sv
root_election.sv
boundary_tracker.sv
cluster_state.sv
processing_unit.sv
tb_processing_unit.sv

//--- cluster_state.sv
`timescale 1ns/1ns

module cluster_state #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           in_loading,
    input  logic                                           in_spread,
    input  logic                                           in_sync,
    input  logic                                           entering_sync,
    input  logic                                           entering_grow,
    input  logic                                           init_is_error_syndrome,
    input  pu_pkg::address_t                               new_root,
    input  logic                                           any_accepted,
    input  logic                                           boundary_reached,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] spread_out_old_roots,
    output pu_pkg::address_t                               old_root,
    output pu_pkg::address_t                               updated_root,
    output logic                                           is_error_syndrome,
    output logic                                           is_odd_cluster,
    output logic                                           is_touching_boundary,
    output logic                                           neighbor_increase,
    output logic                                           union_out_valid,
    output pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_out_old_roots,
    output pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_out_updated_roots
);
    import pu_pkg::*;

    address_t address;
    logic self_odd;         // we are an odd root clear of any boundary
    logic root_changed;
    logic sync_broadcast;

    assign address = {
        PER_DIMENSION_WIDTH'(K),
        PER_DIMENSION_WIDTH'(I),
        PER_DIMENSION_WIDTH'(J)
    };

    assign self_odd = (address == updated_root)
        && !is_touching_boundary
        && is_error_syndrome;

    assign root_changed = (new_root != updated_root);

    always_ff @(posedge clk) begin
        if (reset) begin
            old_root <= address;
            updated_root <= address;
            is_error_syndrome <= 1'b0;
            is_odd_cluster <= 1'b0;
            is_touching_boundary <= 1'b0;
        end else if (in_loading) begin
            old_root <= address;
            updated_root <= address;
            is_error_syndrome <= init_is_error_syndrome;
            is_odd_cluster <= init_is_error_syndrome; // single node cluster
            is_touching_boundary <= 1'b0;
        end else if (in_spread) begin
            updated_root <= new_root;
            if (boundary_reached) begin
                is_touching_boundary <= 1'b1;
            end
        end else if (in_sync) begin
            if (entering_sync) begin
                // only the root seeds the flag, members learn it by broadcast
                is_odd_cluster <= self_odd;
                old_root <= updated_root;
            end else if (any_accepted) begin
                is_odd_cluster <= 1'b1;
            end
        end
    end

    // forward the flag once, on the cycle it first turns on
    assign sync_broadcast = in_sync
        && (entering_sync ? self_odd : (any_accepted && !is_odd_cluster));

    assign union_out_valid = (in_spread && root_changed) || sync_broadcast;

    for (genvar n = 0; n < NEIGHBOR_COUNT; n++) begin : g_out
        assign union_out_old_roots[n] = sync_broadcast ? updated_root
                                                       : spread_out_old_roots[n];
        assign union_out_updated_roots[n] = sync_broadcast ? updated_root : new_root;
    end

    assign neighbor_increase = entering_grow && is_odd_cluster; // one pulse per grow

    // root can only fall below our own address, never rise above it
    a_root_below_address: assert property (
        @(posedge clk) disable iff (reset)
        updated_root <= address
    ) else $error("updated root %0h above own address %0h", updated_root, address);

endmodule

//--- processing_unit.sv
`timescale 1ns/1ns

module processing_unit #(
    parameter int I = 0,
    parameter int J = 0,
    parameter int K = 0
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  pu_pkg::stage_t                                 stage_in,
    input  logic                                           init_is_error_syndrome,
    input  logic [pu_pkg::NEIGHBOR_COUNT-1:0]             neighbor_is_fully_grown,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] neighbor_old_roots,
    input  logic [pu_pkg::NEIGHBOR_COUNT-1:0]             union_in_valid,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_in_old_roots,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_in_updated_roots,
    output logic                                           neighbor_increase,
    output logic                                           union_out_valid,
    output pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_out_old_roots,
    output pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_out_updated_roots,
    output pu_pkg::address_t                               old_root,
    output pu_pkg::address_t                               updated_root,
    output logic                                           is_error_syndrome,
    output logic                                           is_odd_cluster,
    output logic                                           is_touching_boundary,
    output logic                                           is_busy
);
    import pu_pkg::*;

    stage_t stage;
    logic in_spread;
    logic in_sync;
    logic entering_grow;
    logic entering_sync;
    logic in_loading;
    logic any_accepted;
    logic boundary_reached;
    address_t new_root;
    address_t [NEIGHBOR_COUNT-1:0] spread_out_old_roots;

    // each coordinate has to fit its field of the address
    if ((I >= (1 << PER_DIMENSION_WIDTH)) || (J >= (1 << PER_DIMENSION_WIDTH))
            || (K >= (1 << PER_DIMENSION_WIDTH))) begin : g_bad_coordinate
        $error("coordinate (%0d,%0d,%0d) does not fit the address", I, J, K);
    end

    stage_tracker u_stage_tracker (
        .clk           (clk),
        .reset         (reset),
        .stage_in      (stage_in),
        .stage         (stage),
        .in_spread     (in_spread),
        .in_sync       (in_sync),
        .entering_grow (entering_grow),
        .entering_sync (entering_sync),
        .in_loading    (in_loading)
    );

    root_election u_root_election (
        .old_root                (old_root),
        .updated_root            (updated_root),
        .neighbor_old_roots      (neighbor_old_roots),
        .union_in_old_roots      (union_in_old_roots),
        .union_in_updated_roots  (union_in_updated_roots),
        .neighbor_is_fully_grown (neighbor_is_fully_grown),
        .union_in_valid          (union_in_valid),
        .new_root                (new_root),
        .any_accepted            (any_accepted),
        .spread_out_old_roots    (spread_out_old_roots)
    );

    boundary_tracker #(.I(I), .J(J), .K(K)) u_boundary_tracker (
        .clk              (clk),
        .reset            (reset),
        .in_loading       (in_loading),
        .entering_grow    (entering_grow),
        .is_odd_cluster   (is_odd_cluster),
        .boundary_reached (boundary_reached)
    );

    cluster_state #(.I(I), .J(J), .K(K)) u_cluster_state (
        .clk                     (clk),
        .reset                   (reset),
        .in_loading              (in_loading),
        .in_spread               (in_spread),
        .in_sync                 (in_sync),
        .entering_sync           (entering_sync),
        .entering_grow           (entering_grow),
        .init_is_error_syndrome  (init_is_error_syndrome),
        .new_root                (new_root),
        .any_accepted            (any_accepted),
        .boundary_reached        (boundary_reached),
        .spread_out_old_roots    (spread_out_old_roots),
        .old_root                (old_root),
        .updated_root            (updated_root),
        .is_error_syndrome       (is_error_syndrome),
        .is_odd_cluster          (is_odd_cluster),
        .is_touching_boundary    (is_touching_boundary),
        .neighbor_increase       (neighbor_increase),
        .union_out_valid         (union_out_valid),
        .union_out_old_roots     (union_out_old_roots),
        .union_out_updated_roots (union_out_updated_roots)
    );

    assign is_busy = union_out_valid || (|union_in_valid); // traffic still in flight

    // outputs to neighbors only move in the stages that own them
    a_union_stage: assert property (
        @(posedge clk) disable iff (reset)
        union_out_valid |-> (stage inside {STAGE_SPREAD_CLUSTER, STAGE_SYNC_IS_ODD_CLUSTER})
    ) else $error("union message outside spread or sync");

    a_increase_stage: assert property (
        @(posedge clk) disable iff (reset)
        neighbor_increase |-> (stage == STAGE_GROW_BOUNDARY)
    ) else $error("neighbor_increase outside grow stage");

endmodule

//--- pu_pkg.sv
package pu_pkg;

    // address layout is {k, i, j}
    localparam int PER_DIMENSION_WIDTH = 5;
    localparam int ADDRESS_WIDTH = 3 * PER_DIMENSION_WIDTH;

    // one link per direct neighbor in the lattice
    localparam int NEIGHBOR_COUNT = 4;

    // the min tree is padded up to a power of two
    localparam int MIN_TREE_LEAVES = 1 << $clog2(NEIGHBOR_COUNT);
    localparam int MIN_TREE_NODES = 2 * MIN_TREE_LEAVES - 1;

    localparam int BOUNDARY_WIDTH = 2;
    localparam int CODE_DISTANCE_Z = 5; // z boundary sits on j == 0 and j == d - 1

    localparam int STAGE_WIDTH = 3;

    typedef logic [ADDRESS_WIDTH-1:0] address_t;
    typedef logic [BOUNDARY_WIDTH-1:0] boundary_count_t;

    // grow steps until the boundary is reached
    localparam boundary_count_t BOUNDARY_COST_Z = 2'd2;
    localparam boundary_count_t BOUNDARY_COST_UD = 2'd2;

    // stage encoding shared by the whole decoder array
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_SPREAD_CLUSTER      = 3'd1,
        STAGE_GROW_BOUNDARY       = 3'd2,
        STAGE_SYNC_IS_ODD_CLUSTER = 3'd3,
        STAGE_MEASUREMENT_LOADING = 3'd4
    } stage_t;

endpackage

//--- root_election.sv
`timescale 1ns/1ns

module root_election (
    input  pu_pkg::address_t                               old_root,
    input  pu_pkg::address_t                               updated_root,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] neighbor_old_roots,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_in_old_roots,
    input  pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] union_in_updated_roots,
    input  logic [pu_pkg::NEIGHBOR_COUNT-1:0]             neighbor_is_fully_grown,
    input  logic [pu_pkg::NEIGHBOR_COUNT-1:0]             union_in_valid,
    output pu_pkg::address_t                               new_root,
    output logic                                           any_accepted,
    output pu_pkg::address_t [pu_pkg::NEIGHBOR_COUNT-1:0] spread_out_old_roots
);
    import pu_pkg::*;

    logic [NEIGHBOR_COUNT-1:0] accepted;        // message addressed to our cluster
    logic [NEIGHBOR_COUNT-1:0] candidate_valid;
    address_t [NEIGHBOR_COUNT-1:0] candidate;
    logic elected_is_min;   // nothing valid sits below the winner

    // heap ordered min tree with node 0 as its root
    // leaves start at MIN_TREE_LEAVES - 1
    address_t tree [MIN_TREE_NODES];

    for (genvar n = 0; n < NEIGHBOR_COUNT; n++) begin : g_link
        // mismatching old root means the message belongs to another cluster
        assign accepted[n] = union_in_valid[n]
            && (union_in_old_roots[n] == old_root);

        assign candidate_valid[n] = accepted[n] || neighbor_is_fully_grown[n];

        // a fresh message wins over the link's stale root
        assign candidate[n] = accepted[n] ? union_in_updated_roots[n]
                                          : neighbor_old_roots[n];

        // tell grown neighbors which cluster they used to be part of
        assign spread_out_old_roots[n] = neighbor_is_fully_grown[n]
            ? neighbor_old_roots[n]
            : old_root;
    end

    assign any_accepted = |accepted;

    // invalid and padding leaves fall back to our own updated root
    for (genvar l = 0; l < MIN_TREE_LEAVES; l++) begin : g_leaf
        if (l < NEIGHBOR_COUNT) begin : g_used
            assign tree[MIN_TREE_LEAVES - 1 + l] = candidate_valid[l]
                ? candidate[l]
                : updated_root;
        end else begin : g_pad
            assign tree[MIN_TREE_LEAVES - 1 + l] = updated_root;
        end
    end

    for (genvar t = 0; t < MIN_TREE_LEAVES - 1; t++) begin : g_node
        assign tree[t] = (tree[2 * t + 1] <= tree[2 * t + 2])
            ? tree[2 * t + 1]
            : tree[2 * t + 2];
    end

    // own updated root always takes part, even with every link valid
    assign new_root = (tree[0] <= updated_root) ? tree[0] : updated_root;

    // roots only ever move downward and the tree keeps the smallest candidate
    always_comb begin
        elected_is_min = 1'b1;
        if (new_root > updated_root) begin
            elected_is_min = 1'b0;
        end
        for (int c = 0; c < NEIGHBOR_COUNT; c++) begin
            if (candidate_valid[c] && (candidate[c] < new_root)) begin
                elected_is_min = 1'b0;
            end
        end
        a_root_is_minimum: assert final (elected_is_min)
            else $error("elected root %0h is not the smallest candidate", new_root);
    end

endmodule

//--- stage_tracker.sv
`timescale 1ns/1ns

module stage_tracker (
    input  logic           clk,
    input  logic           reset,
    input  pu_pkg::stage_t stage_in,
    output pu_pkg::stage_t stage,
    output logic           in_spread,
    output logic           in_sync,
    output logic           entering_grow,
    output logic           entering_sync,
    output logic           in_loading
);
    import pu_pkg::*;

    stage_t last_stage; // stage seen one cycle earlier

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            last_stage <= STAGE_IDLE;
        end else begin
            stage <= stage_in;
            // loading forgets history so the next stage always counts as new
            if (stage == STAGE_MEASUREMENT_LOADING) begin
                last_stage <= STAGE_IDLE;
            end else begin
                last_stage <= stage;
            end
        end
    end

    assign in_spread = (stage == STAGE_SPREAD_CLUSTER);
    assign in_sync = (stage == STAGE_SYNC_IS_ODD_CLUSTER);
    assign in_loading = (stage == STAGE_MEASUREMENT_LOADING);

    // entry strobes, high only in the first cycle of a stage
    assign entering_grow = (stage == STAGE_GROW_BOUNDARY)
        && (last_stage != STAGE_GROW_BOUNDARY);
    assign entering_sync = (stage == STAGE_SYNC_IS_ODD_CLUSTER)
        && (last_stage != STAGE_SYNC_IS_ODD_CLUSTER);

    // controller must only ever send one of the five defined stages
    a_stage_in_legal: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(stage_in) && (stage_in inside {
            STAGE_IDLE,
            STAGE_SPREAD_CLUSTER,
            STAGE_GROW_BOUNDARY,
            STAGE_SYNC_IS_ODD_CLUSTER,
            STAGE_MEASUREMENT_LOADING
        })
    ) else $error("illegal stage_in value %0d", stage_in);

endmodule

//--- pu_ref_model.svh
`ifndef PU_REF_MODEL_SVH
`define PU_REF_MODEL_SVH

// registered state of the unit as the model sees it
stage_t   m_stage;
stage_t   m_last_stage;
address_t m_old_root;
address_t m_updated_root;
logic     m_syndrome;
logic     m_odd;
logic     m_touching;
int       m_grows;          // grow steps of an odd cluster since loading

// predictions for the current cycle
address_t m_new_root;
logic     m_accepted;
logic     m_self_odd;
logic     m_entering_grow;
logic     m_entering_sync;
logic     m_broadcast;
logic     m_union_valid;
logic     m_increase;
logic     m_busy;
address_t m_out_old [NEIGHBOR_COUNT];
address_t m_out_updated [NEIGHBOR_COUNT];

// boundaries follow from the coordinates, no saturation needed here
function automatic logic boundary_hit();
    logic has_z;
    logic has_ud;
    has_z = (TB_J == 0) || (TB_J == CODE_DISTANCE_Z - 1);
    has_ud = (TB_K == 0);
    return (has_z && (m_grows >= BOUNDARY_COST_Z)) || (has_ud && (m_grows >= BOUNDARY_COST_UD));
endfunction

task automatic model_predict();
    int n;
    logic acc;
    address_t cand;
    m_accepted = 1'b0;
    m_new_root = m_updated_root;
    for (n = 0; n < NEIGHBOR_COUNT; n++) begin
        acc = union_in_valid[n] && (union_in_old_roots[n] == m_old_root);
        cand = acc ? union_in_updated_roots[n] : neighbor_old_roots[n];
        if (acc) m_accepted = 1'b1;
        if ((acc || neighbor_is_fully_grown[n]) && (cand < m_new_root)) m_new_root = cand;
    end
    m_entering_grow = (m_stage == STAGE_GROW_BOUNDARY) && (m_last_stage != STAGE_GROW_BOUNDARY);
    m_entering_sync = (m_stage == STAGE_SYNC_IS_ODD_CLUSTER)
        && (m_last_stage != STAGE_SYNC_IS_ODD_CLUSTER);
    m_self_odd = (m_updated_root == OWN_ADDRESS) && !m_touching && m_syndrome;
    m_broadcast = 1'b0;
    if (m_stage == STAGE_SYNC_IS_ODD_CLUSTER) begin
        // flag news goes out only when it turns the flag on
        m_broadcast = m_entering_sync ? m_self_odd : (m_accepted && !m_odd);
    end
    m_union_valid = ((m_stage == STAGE_SPREAD_CLUSTER) && (m_new_root != m_updated_root))
        || m_broadcast;
    for (n = 0; n < NEIGHBOR_COUNT; n++) begin
        if (m_broadcast) begin
            m_out_old[n] = m_updated_root;
            m_out_updated[n] = m_updated_root;
        end else begin
            m_out_old[n] = neighbor_is_fully_grown[n] ? neighbor_old_roots[n] : m_old_root;
            m_out_updated[n] = m_new_root;
        end
    end
    m_increase = m_entering_grow && m_odd;
    m_busy = m_union_valid || (|union_in_valid);
endtask

// one rising edge of the unit
task automatic model_step();
    if (reset) begin
        m_stage = STAGE_IDLE;
        m_last_stage = STAGE_IDLE;
        m_old_root = OWN_ADDRESS;
        m_updated_root = OWN_ADDRESS;
        m_syndrome = 1'b0;
        m_odd = 1'b0;
        m_touching = 1'b0;
        m_grows = 0;
    end else begin
        model_predict();
        case (m_stage)
            STAGE_MEASUREMENT_LOADING: begin
                m_old_root = OWN_ADDRESS;
                m_updated_root = OWN_ADDRESS;
                m_syndrome = init_is_error_syndrome;
                m_odd = init_is_error_syndrome;
                m_touching = 1'b0;
                m_grows = 0;
            end
            STAGE_SPREAD_CLUSTER: begin
                m_updated_root = m_new_root;
                if (boundary_hit()) m_touching = 1'b1;
            end
            STAGE_SYNC_IS_ODD_CLUSTER: begin
                if (m_entering_sync) begin
                    m_odd = m_self_odd;
                    m_old_root = m_updated_root;
                end else if (m_accepted) begin
                    m_odd = 1'b1;
                end
            end
            STAGE_GROW_BOUNDARY: begin
                if (m_entering_grow && m_odd) m_grows++;
            end
            default: ;
        endcase
        m_last_stage = (m_stage == STAGE_MEASUREMENT_LOADING) ? STAGE_IDLE : m_stage;
        m_stage = stage_in;
    end
endtask

`endif

//--- tb_processing_unit.sv
`timescale 1ns/1ns

module tb_processing_unit;
    import pu_pkg::*;

    // i 1, j 0, k 0 gives a unit with both z and ud boundaries
    localparam int TB_I = 1;
    localparam int TB_J = 0;
    localparam int TB_K = 0;
    localparam address_t OWN_ADDRESS = address_t'((TB_K << (2 * PER_DIMENSION_WIDTH))
        | (TB_I << PER_DIMENSION_WIDTH) | TB_J);
    localparam int CLOCK_PERIOD = 20;
    localparam int SEED = 1617;
    localparam int LOAD_ROUNDS = 8;
    localparam int SPREAD_ROUNDS = 10;
    localparam int SPREAD_LEN = 12;
    localparam int GROW_ROUNDS = 8;
    localparam int SYNC_ROUNDS = 12;
    localparam int SYNC_LEN = 6;
    localparam int RANDOM_CYCLES = 2000;
    localparam int TOTAL_CYCLES = 4 + LOAD_ROUNDS * 4 + SPREAD_ROUNDS * (1 + SPREAD_LEN)
        + GROW_ROUNDS * 14 + SYNC_ROUNDS * (4 + SYNC_LEN) + RANDOM_CYCLES;

    logic clk;
    logic reset;
    stage_t stage_in;
    logic init_is_error_syndrome;
    logic [NEIGHBOR_COUNT-1:0] neighbor_is_fully_grown;
    logic [NEIGHBOR_COUNT-1:0] union_in_valid;
    address_t [NEIGHBOR_COUNT-1:0] neighbor_old_roots;
    address_t [NEIGHBOR_COUNT-1:0] union_in_old_roots;
    address_t [NEIGHBOR_COUNT-1:0] union_in_updated_roots;
    logic neighbor_increase;
    logic union_out_valid;
    address_t [NEIGHBOR_COUNT-1:0] union_out_old_roots;
    address_t [NEIGHBOR_COUNT-1:0] union_out_updated_roots;
    address_t old_root;
    address_t updated_root;
    logic is_error_syndrome;
    logic is_odd_cluster;
    logic is_touching_boundary;
    logic is_busy;

    int check_count;
    int error_count;
    string test_name;

    processing_unit #(.I(TB_I), .J(TB_J), .K(TB_K)) uut (
        .clk                     (clk),
        .reset                   (reset),
        .stage_in                (stage_in),
        .init_is_error_syndrome  (init_is_error_syndrome),
        .neighbor_is_fully_grown (neighbor_is_fully_grown),
        .neighbor_old_roots      (neighbor_old_roots),
        .union_in_valid          (union_in_valid),
        .union_in_old_roots      (union_in_old_roots),
        .union_in_updated_roots  (union_in_updated_roots),
        .neighbor_increase       (neighbor_increase),
        .union_out_valid         (union_out_valid),
        .union_out_old_roots     (union_out_old_roots),
        .union_out_updated_roots (union_out_updated_roots),
        .old_root                (old_root),
        .updated_root            (updated_root),
        .is_error_syndrome       (is_error_syndrome),
        .is_odd_cluster          (is_odd_cluster),
        .is_touching_boundary    (is_touching_boundary),
        .is_busy                 (is_busy)
    );

    `include "pu_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) model_step();

    initial begin
        #((TOTAL_CYCLES + 50) * CLOCK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TOTAL_CYCLES + 50);
        $display("test failed");
        $finish;
    end

    // near the own address so minima and root matches both show up
    function automatic address_t near_address();
        return address_t'(OWN_ADDRESS + 3 - ($urandom % 12));
    endfunction

    function automatic stage_t random_stage();
        case ($urandom % 8)
            0: return STAGE_MEASUREMENT_LOADING;
            1, 2: return STAGE_SPREAD_CLUSTER;
            3, 4: return STAGE_GROW_BOUNDARY;
            5, 6: return STAGE_SYNC_IS_ODD_CLUSTER;
            default: return STAGE_IDLE;
        endcase
    endfunction

    task automatic check_value(input string signal, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Mismatch in %s on %s: expected %0h, actual %0h",
                     test_name, signal, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        int n;
        model_predict();
        check_value("union_out_valid", m_union_valid, union_out_valid);
        check_value("neighbor_increase", m_increase, neighbor_increase);
        check_value("is_busy", m_busy, is_busy);
        check_value("old_root", m_old_root, old_root);
        check_value("updated_root", m_updated_root, updated_root);
        check_value("is_error_syndrome", m_syndrome, is_error_syndrome);
        check_value("is_odd_cluster", m_odd, is_odd_cluster);
        check_value("is_touching_boundary", m_touching, is_touching_boundary);
        for (n = 0; n < NEIGHBOR_COUNT; n++) begin
            check_value($sformatf("union_out_old_roots[%0d]", n), m_out_old[n],
                        union_out_old_roots[n]);
            check_value($sformatf("union_out_updated_roots[%0d]", n), m_out_updated[n],
                        union_out_updated_roots[n]);
        end
    endtask

    // syndrome_choice 0 or 1 forces the syndrome, anything else draws it
    task automatic drive_cycle(input stage_t s, input int grow_pct, input int msg_pct,
                               input int syndrome_choice);
        int n;
        @(negedge clk);
        stage_in = s;
        init_is_error_syndrome = (syndrome_choice < 2) ? syndrome_choice[0] : $urandom % 2;
        for (n = 0; n < NEIGHBOR_COUNT; n++) begin
            neighbor_is_fully_grown[n] = ($urandom % 100) < grow_pct;
            neighbor_old_roots[n] = near_address();
            union_in_valid[n] = ($urandom % 100) < msg_pct;
            union_in_old_roots[n] = ($urandom % 2) ? m_old_root : near_address();
            union_in_updated_roots[n] = near_address();
        end
        #1;
        compare_outputs();
    endtask

    initial begin
        int round;
        stage_t next_stage;
        void'($urandom(SEED));
        check_count = 0;
        error_count = 0;
        reset = 1'b1;
        stage_in = STAGE_IDLE;
        init_is_error_syndrome = 1'b0;
        neighbor_is_fully_grown = '0;
        union_in_valid = '0;
        neighbor_old_roots = '0;
        union_in_old_roots = '0;
        union_in_updated_roots = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        test_name = "reset";
        compare_outputs();

        test_name = "loading";
        for (round = 0; round < LOAD_ROUNDS; round++) begin
            drive_cycle(STAGE_MEASUREMENT_LOADING, 0, 0, 2);
            repeat (3) drive_cycle(STAGE_IDLE, 0, 0, 2);
        end

        test_name = "spread";
        for (round = 0; round < SPREAD_ROUNDS; round++) begin
            drive_cycle(STAGE_MEASUREMENT_LOADING, 0, 0, 2);
            repeat (SPREAD_LEN) drive_cycle(STAGE_SPREAD_CLUSTER, 40, 40, 2);
        end

        test_name = "grow";     // even rounds load an even cluster
        for (round = 0; round < GROW_ROUNDS; round++) begin
            drive_cycle(STAGE_MEASUREMENT_LOADING, 0, 0, round % 2);
            repeat (3) begin
                repeat (2) drive_cycle(STAGE_GROW_BOUNDARY, 20, 0, 2);
                repeat (2) drive_cycle(STAGE_SPREAD_CLUSTER, 20, 0, 2);
            end
            drive_cycle(STAGE_IDLE, 0, 0, 2);
        end

        test_name = "sync";
        for (round = 0; round < SYNC_ROUNDS; round++) begin
            drive_cycle(STAGE_MEASUREMENT_LOADING, 0, 0, 2);
            repeat (3) drive_cycle(STAGE_SPREAD_CLUSTER, 30, 20, 2);
            repeat (SYNC_LEN) drive_cycle(STAGE_SYNC_IS_ODD_CLUSTER, 30, 30, 2);
        end

        test_name = "random";
        next_stage = STAGE_IDLE;
        repeat (RANDOM_CYCLES) begin
            if (($urandom % 3) == 0) next_stage = random_stage();
            drive_cycle(next_stage, 40, 30, 2);
        end

        $display("%0d checks, %0d mismatches", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
